//--- Bender.yml
package:
  name: mmio_regs

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mmio_pkg.sv
      - logic/mmio_decode.sv
      - logic/mmio_regfile.sv
      - logic/soft_reset_gen.sv
      - logic/mmio_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/mmio_chk.sv
      - bench/mmio_tb.sv

//--- bench/mmio_chk.sv
/* Handshake and strobe assertions, bound into every mmio_top instance */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module mmio_chk (
   input wire                      clk,
   input wire                      rst_n,
   input wire                      mmio_wr,
   input wire                      mmio_rd,
   input wire                      mmio_done,
   input wire                      mmio_failed,
   input wire                      debug_cnt_clear,
   input wire                      soft_reset
);

   // ====================
   a_one_answer: assert property (@(posedge clk) disable iff (!rst_n)
      !(mmio_done && mmio_failed))
      else $error("done and failed high in the same cycle");

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (mmio_wr || mmio_rd) |-> ##2 (mmio_done ^ mmio_failed))
      else $error("request not answered two cycles later");

   a_clear_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      debug_cnt_clear |=> !debug_cnt_clear)
      else $error("debug_cnt_clear high for two cycles");

   a_soft_reset_len: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(soft_reset) |-> soft_reset [*`SOFT_RESET_CYCLES] ##1 !soft_reset)
      else $error("soft_reset pulse has the wrong length");

endmodule

bind mmio_top mmio_chk chk (
   .clk(clk), .rst_n(rst_n),
   .mmio_wr(mmio_wr), .mmio_rd(mmio_rd),
   .mmio_done(mmio_done), .mmio_failed(mmio_failed),
   .debug_cnt_clear(debug_cnt_clear), .soft_reset(soft_reset)
);

`default_nettype wire

//--- bench/mmio_tb.sv
/* Directed testbench for mmio_top, one request in flight per table entry
   Debug and FIR inputs are random from a fixed seed and held for the whole run */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module mmio_tb;

   localparam int  NUM_ENTRIES = 19;
   localparam int  CLK_PERIOD  = 40;
   localparam time WATCHDOG    = (NUM_ENTRIES * 6 + 200) * CLK_PERIOD;
   localparam int  SIDE_NONE = 0, SIDE_CLR = 1, SIDE_SRST = 2, SIDE_LIM = 3;   // Extra checks

   logic clk, rst_n, mmio_wr, mmio_rd, mmio_dw;
   logic [`MMIO_ADDR_W-1:0] mmio_addr;
   logic [`MMIO_DATA_W-1:0] mmio_din;
   logic [`MMIO_DATA_W-1:0] tlx_cmd, tlx_rsp, buf_cnt, fifo_ovfl, tlx_intrfc;
   wire  [`MMIO_DATA_W-1:0] mmio_dout, idle_lim;
   wire                     mmio_done, mmio_failed, cnt_clear, soft_reset;

   // ====================
   // Stimulus table, one slot per test
   string                   t_name  [NUM_ENTRIES];
   logic                    t_write [NUM_ENTRIES];
   logic                    t_dw    [NUM_ENTRIES];
   logic [`MMIO_ADDR_W-1:0] t_addr  [NUM_ENTRIES];
   logic [`MMIO_DATA_W-1:0] t_wdata [NUM_ENTRIES];
   logic                    t_fail  [NUM_ENTRIES];   // Expect failed
   logic [`MMIO_DATA_W-1:0] t_exp   [NUM_ENTRIES];
   logic                    t_chk   [NUM_ENTRIES];   // Compare read data
   int                      t_side  [NUM_ENTRIES];
   int     n_tab = 0;
   int     errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   integer seed = 47484;

   mmio_top dut (
      .clk(clk), .rst_n(rst_n),
      .mmio_wr(mmio_wr), .mmio_rd(mmio_rd), .mmio_dw(mmio_dw),
      .mmio_addr(mmio_addr), .mmio_din(mmio_din),
      .mmio_dout(mmio_dout), .mmio_done(mmio_done), .mmio_failed(mmio_failed),
      .debug_tlx_cnt_cmd(tlx_cmd), .debug_tlx_cnt_rsp(tlx_rsp), .debug_buf_cnt(buf_cnt),
      .fir_fifo_overflow(fifo_ovfl), .fir_tlx_interface(tlx_intrfc),
      .debug_cnt_clear(cnt_clear), .debug_tlx_idle_lim(idle_lim), .soft_reset(soft_reset)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Address bits 31:22 stay 0, base in 21:8, offset in 7:0
   function automatic logic [`MMIO_ADDR_W-1:0] addr_of(input logic [13:0] base,
                                                        input logic [7:0] ofs);
      return {10'd0, base, ofs};
   endfunction

   task automatic add_entry(input string name, input logic wr, input logic dw,
                            input logic [31:0] addr, input logic [63:0] wdata, input logic fail,
                            input logic [63:0] exp, input logic chk, input int side);
      t_name[n_tab]  = name;
      t_write[n_tab] = wr;
      t_dw[n_tab]    = dw;
      t_addr[n_tab]  = addr;
      t_wdata[n_tab] = wdata;
      t_fail[n_tab]  = fail;
      t_exp[n_tab]   = exp;
      t_chk[n_tab]   = chk;
      t_side[n_tab]  = side;
      n_tab++;
   endtask

   task automatic build_table();
      logic [63:0] cap = '0;
      logic [63:0] stat = '0;
      logic [63:0] lim = {$random(seed), $random(seed)};
      cap[39:36] = `DMA_XFER_SIZE;                   // Capability layout
      cap[35:32] = `DMA_ALIGNMENT;
      cap[31:16] = `SDRAM_SIZE;
      cap[7:0]   = `CARD_TYPE;
      stat[0] = (buf_cnt == '0);                     // Idle
      stat[1] = (tlx_cmd != tlx_rsp);                // TLX busy
      stat[3] = (fifo_ovfl != '0) || (tlx_intrfc != '0);   // Fatal
      add_entry("rd_ivr", 0, 1, addr_of(`BASE_SNAP, `OFS_IVR), '0, 0, `IMP_VERSION, 1, SIDE_NONE);
      add_entry("rd_bdr", 0, 1, addr_of(`BASE_SNAP, `OFS_BDR), '0, 0, `BUILD_DATE, 1, SIDE_NONE);
      add_entry("rd_cap", 0, 1, addr_of(`BASE_SNAP, `OFS_CAP), '0, 0, cap, 1, SIDE_NONE);
      add_entry("rd_ssr", 0, 1, addr_of(`BASE_SNAP, `OFS_SSR), '0, 0, stat, 1, SIDE_NONE);
      add_entry("rd_tlx_cmd", 0, 1, addr_of(`BASE_DEBUG, `OFS_TLX_CMD), '0, 0, tlx_cmd, 1, 0);
      add_entry("rd_tlx_rsp", 0, 1, addr_of(`BASE_DEBUG, `OFS_TLX_RSP), '0, 0, tlx_rsp, 1, 0);
      add_entry("rd_buf_cnt", 0, 1, addr_of(`BASE_DEBUG, `OFS_BUF_CNT), '0, 0, buf_cnt, 1, 0);
      add_entry("rd_fifo_ovfl", 0, 1, addr_of(`BASE_FIR, `OFS_FIFO_OVFL), '0, 0, fifo_ovfl, 1, 0);
      add_entry("rd_tlx_intrfc", 0, 1, addr_of(`BASE_FIR, `OFS_TLX_INTRFC), '0, 0,
                tlx_intrfc, 1, SIDE_NONE);
      add_entry("wr_idle_lim", 1, 1, addr_of(`BASE_DEBUG, `OFS_TLX_IDLE_LIM), lim, 0, lim, 0,
                SIDE_LIM);
      add_entry("rd_idle_lim", 0, 1, addr_of(`BASE_DEBUG, `OFS_TLX_IDLE_LIM), '0, 0, lim, 1,
                SIDE_LIM);
      // Refused accesses
      add_entry("rd_action", 0, 1, addr_of(`BASE_SNAP, `OFS_IVR) | 32'h8000_0000, '0, 1, '0, 0, 0);
      add_entry("rd_dw_zero", 0, 0, addr_of(`BASE_SNAP, `OFS_IVR), '0, 1, '0, 0, SIDE_NONE);
      add_entry("rd_bad_ofs", 0, 1, addr_of(`BASE_SNAP, 8'h20), '0, 1, '0, 0, SIDE_NONE);
      add_entry("rd_bad_base", 0, 1, addr_of(14'h100, 8'h00), '0, 1, '0, 0, SIDE_NONE);
      add_entry("wr_ivr", 1, 1, addr_of(`BASE_SNAP, `OFS_IVR), 64'h5A5A, 1, '0, 0, SIDE_NONE);
      add_entry("rd_scr", 0, 1, addr_of(`BASE_SNAP, `OFS_SCR), '0, 1, '0, 0, SIDE_NONE);
      // Strobes
      add_entry("wr_dbg_clr", 1, 1, addr_of(`BASE_DEBUG, `OFS_DBG_CLR), 64'h1, 0, '0, 0, SIDE_CLR);
      add_entry("wr_scr", 1, 1, addr_of(`BASE_SNAP, `OFS_SCR), 64'h1, 0, '0, 0, SIDE_SRST);
   endtask

   task automatic drive_req(input logic wr, input logic rd, input logic dw,
                            input logic [31:0] addr, input logic [63:0] din);
      mmio_wr   = wr;
      mmio_rd   = rd;
      mmio_dw   = dw;
      mmio_addr = addr;
      mmio_din  = din;
   endtask

   task automatic check_val(input string name, input string what,
                            input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act)
      else
      begin
         $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before)
         $display("%-16s ok", name);
      else
      begin
         tests_failed++;
         $display("%-16s %0d check(s) wrong", name, errors - errs_before);
      end
   endtask

   // ====================
   // One request at cycle 0, outputs sampled at the falling edge of every cycle
   task automatic run_entry(input int i);
      int win = (t_side[i] == SIDE_SRST) ? 21 : 5;   // Soft reset needs the longer view
      int resp_cnt = 0;
      int resp_cyc = -1;
      int clr_cnt = 0;
      int clr_cyc = -1;
      int sr_cnt = 0;
      int sr_cyc = -1;
      int errs_before = errors;
      logic got_done = 1'b0;
      logic got_failed = 1'b0;
      logic [63:0] got_dout = '0;
      logic [63:0] got_lim = '0;
      for (int c = 0; c <= win; c++)
      begin
         @(posedge clk);
         #2;
         if (c == 0)
            drive_req(t_write[i], !t_write[i], t_dw[i], t_addr[i], t_wdata[i]);
         else
            drive_req(0, 0, 0, '0, '0);
         @(negedge clk);
         if (mmio_done || mmio_failed)
         begin
            if (resp_cnt == 0)
            begin
               resp_cyc   = c;
               got_done   = mmio_done;
               got_failed = mmio_failed;
               got_dout   = mmio_dout;
               got_lim    = idle_lim;
            end
            resp_cnt++;
         end
         if (cnt_clear)
         begin
            if (clr_cnt == 0)
               clr_cyc = c;
            clr_cnt++;
         end
         if (soft_reset)
         begin
            if (sr_cnt == 0)
               sr_cyc = c;
            sr_cnt++;
         end
      end
      assert (resp_cnt > 0)
      else
      begin
         $display("%s: the DUT gave no response to the request", t_name[i]);
         errors++;
      end
      assert (resp_cnt < 2)
      else
      begin
         $display("%s: the DUT answered one request more than once", t_name[i]);
         errors++;
      end
      if (resp_cnt > 0)
      begin
         check_val(t_name[i], "latency", 2, resp_cyc);
         check_val(t_name[i], "failed", t_fail[i], got_failed);
         check_val(t_name[i], "done", !t_fail[i], got_done);
         if (t_chk[i])
            check_val(t_name[i], "data", t_exp[i], got_dout);
         if (t_side[i] == SIDE_LIM)
            check_val(t_name[i], "idle_lim", t_exp[i], got_lim);   // Visible with the response
      end
      check_val(t_name[i], "clear_pulses", (t_side[i] == SIDE_CLR) ? 1 : 0, clr_cnt);
      if (t_side[i] == SIDE_CLR)
         check_val(t_name[i], "clear_cycle", 2, clr_cyc);
      check_val(t_name[i], "soft_reset_len", (t_side[i] == SIDE_SRST) ? 16 : 0, sr_cnt);
      if (t_side[i] == SIDE_SRST)
         check_val(t_name[i], "soft_reset_rise", 3, sr_cyc);
      report_test(t_name[i], errs_before);
   endtask

   // Two FRT reads at cycles 0 and 5
   task automatic frt_interval();
      int n = 0;
      int errs_before = errors;
      int cyc [2];
      logic [63:0] val [2];
      for (int c = 0; c <= 9; c++)
      begin
         @(posedge clk);
         #2;
         if (c == 0 || c == 5)
            drive_req(0, 1, 1, addr_of(`BASE_SNAP, `OFS_FRT), '0);
         else
            drive_req(0, 0, 0, '0, '0);
         @(negedge clk);
         if (mmio_done && n < 2)
         begin
            val[n] = mmio_dout;
            cyc[n] = c;
         end
         if (mmio_done)
            n++;
      end
      assert (n == 2)
      else
      begin
         $display("frt_interval: expected two read responses but saw %0d", n);
         errors++;
      end
      if (n >= 2)
      begin
         check_val("frt_interval", "second_latency", 7, cyc[1]);
         check_val("frt_interval", "delta", 5, val[1] - val[0]);
      end
      report_test("frt_interval", errs_before);
   endtask

   // ====================
   initial
   begin
      rst_n = 1'b0;
      drive_req(0, 0, 0, '0, '0);
      tlx_cmd    = {$random(seed), $random(seed)};
      tlx_rsp    = {$random(seed), $random(seed)};
      buf_cnt    = {$random(seed), $random(seed)};
      fifo_ovfl  = {$random(seed), $random(seed)};
      tlx_intrfc = {$random(seed), $random(seed)};
      build_table();
      repeat (10) @(posedge clk);
      #2 rst_n = 1'b1;
      for (int i = 0; i < n_tab; i++)
         run_entry(i);
      frt_interval();
      $display("Tests run %0d, failed %0d, wrong checks %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // Watchdog sized from the table length
   initial
   begin
      #(WATCHDOG);
      $display("Watchdog expired before all tests finished");
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/mmio_pkg.sv
logic/mmio_decode.sv
logic/mmio_regfile.sv
logic/soft_reset_gen.sv
logic/mmio_top.sv
bench/mmio_chk.sv
bench/mmio_tb.sv

//--- logic/mmio_cfg.svh
/* Register map, field positions and identity constants of the MMIO block
   Host registers are 8 bytes wide. SOFT_RESET_CYCLES must be a power of two, at least 2 */
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// ====================
// Widths and address fields
`define MMIO_ADDR_W        32
`define MMIO_DATA_W        64
`define ACTION_BIT         31      // Action space, always refused
`define BASE_HI            21      // Base group field
`define BASE_LO            8
`define OFS_HI             7       // Byte offset inside a group
`define OFS_LO             0

// ====================
// Group bases, 14 bits wide
`define BASE_SNAP          14'h000
`define BASE_DEBUG         14'h1A0
`define BASE_FIR           14'h1C0

// Offsets inside the SNAP group
`define OFS_IVR            8'h00   // RO
`define OFS_BDR            8'h08   // RO
`define OFS_SCR            8'h10   // WO, bit 0 starts soft reset
`define OFS_SSR            8'h18   // RO
`define OFS_CAP            8'h30   // RO
`define OFS_FRT            8'h40   // RO

// Offsets inside the DEBUG group
`define OFS_DBG_CLR        8'h00   // WO, self-clearing
`define OFS_TLX_CMD        8'h08
`define OFS_TLX_RSP        8'h10
`define OFS_BUF_CNT        8'h50
`define OFS_TLX_IDLE_LIM   8'h60   // RW

// Offsets inside the FIR group
`define OFS_FIFO_OVFL      8'h00
`define OFS_TLX_INTRFC     8'h08

// ====================
// Identity and soft reset
`define IMP_VERSION        64'h0000_0001_0004_0000
`define BUILD_DATE         64'h0000_0000_0000_1A2B
`define CARD_TYPE          8'h31
`define SDRAM_SIZE         16'h2000  // In MB
`define DMA_XFER_SIZE      4'h7
`define DMA_ALIGNMENT      4'h6
`define SOFT_RESET_CYCLES  16

`endif

//--- logic/mmio_decode.sv
/* Stage 1: access checks and address decode, one cycle of latency
   Expects single-cycle mmio_wr or mmio_rd pulses, never both together */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module mmio_decode (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      mmio_wr,     // Write pulse
   input  wire                      mmio_rd,     // Read pulse
   input  wire                      mmio_dw,     // 1 = 8-byte access
   input  wire [`MMIO_ADDR_W-1:0]   mmio_addr,
   input  wire [`MMIO_DATA_W-1:0]   mmio_din,
   output logic                     req_valid,
   output mmio_pkg::access_e        req_kind,
   output mmio_pkg::reg_sel_e       req_sel,     // SEL_NONE whenever req_err
   output logic                     req_err,
   output logic [`MMIO_DATA_W-1:0]  req_wdata
);

   logic [`BASE_HI-`BASE_LO:0] base;
   logic [`OFS_HI-`OFS_LO:0]   ofs;
   mmio_pkg::reg_sel_e         sel;
   logic                       wr_only;
   logic                       rd_only;
   logic                       err;

   assign base = mmio_addr[`BASE_HI:`BASE_LO];
   assign ofs  = mmio_addr[`OFS_HI:`OFS_LO];

   // ====================
   // Base + offset to register select
   always_comb
   begin
      sel = mmio_pkg::SEL_NONE;
      case (base)
         `BASE_SNAP:
            case (ofs)
               `OFS_IVR: sel = mmio_pkg::SEL_IVR;
               `OFS_BDR: sel = mmio_pkg::SEL_BDR;
               `OFS_SCR: sel = mmio_pkg::SEL_SCR;
               `OFS_SSR: sel = mmio_pkg::SEL_SSR;
               `OFS_CAP: sel = mmio_pkg::SEL_CAP;
               `OFS_FRT: sel = mmio_pkg::SEL_FRT;
               default:  sel = mmio_pkg::SEL_NONE;
            endcase
         `BASE_DEBUG:
            case (ofs)
               `OFS_DBG_CLR:      sel = mmio_pkg::SEL_DBG_CLR;
               `OFS_TLX_CMD:      sel = mmio_pkg::SEL_TLX_CMD;
               `OFS_TLX_RSP:      sel = mmio_pkg::SEL_TLX_RSP;
               `OFS_BUF_CNT:      sel = mmio_pkg::SEL_BUF_CNT;
               `OFS_TLX_IDLE_LIM: sel = mmio_pkg::SEL_TLX_IDLE_LIM;
               default:           sel = mmio_pkg::SEL_NONE;
            endcase
         `BASE_FIR:
            case (ofs)
               `OFS_FIFO_OVFL:  sel = mmio_pkg::SEL_FIFO_OVFL;
               `OFS_TLX_INTRFC: sel = mmio_pkg::SEL_TLX_INTRFC;
               default:         sel = mmio_pkg::SEL_NONE;
            endcase
         default: sel = mmio_pkg::SEL_NONE;   // Unknown group
      endcase
   end

   // Direction rules
   assign wr_only = (sel == mmio_pkg::SEL_SCR) || (sel == mmio_pkg::SEL_DBG_CLR);
   assign rd_only = !(wr_only || (sel == mmio_pkg::SEL_TLX_IDLE_LIM));

   // Action space, 4-byte width, no match, wrong direction
   assign err = mmio_addr[`ACTION_BIT] || !mmio_dw || (sel == mmio_pkg::SEL_NONE) ||
                (mmio_wr && rd_only) || (mmio_rd && wr_only);

   // ====================
   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         req_valid <= 1'b0;
         req_kind  <= mmio_pkg::ACC_READ;
         req_sel   <= mmio_pkg::SEL_NONE;
         req_err   <= 1'b0;
      end
      else
      begin
         req_valid <= mmio_wr || mmio_rd;
         req_kind  <= mmio_wr ? mmio_pkg::ACC_WRITE : mmio_pkg::ACC_READ;
         req_sel   <= err ? mmio_pkg::SEL_NONE : sel;   // Refused access touches nothing
         req_err   <= err;
      end

   // Write data, loaded on writes only
   always_ff @(posedge clk)
      if (mmio_wr)
         req_wdata <= mmio_din;

endmodule

`default_nettype wire

//--- logic/mmio_pkg.sv
/* Shared types of the MMIO pipeline */
`default_nettype none

package mmio_pkg;

   // ====================
   // Register select, one value per implemented register
   typedef enum logic [3:0] {
      SEL_IVR,            // Implementation version
      SEL_BDR,            // Build date
      SEL_SCR,            // Command, write only
      SEL_SSR,            // Status
      SEL_CAP,            // Capability
      SEL_FRT,            // Free-running time
      SEL_DBG_CLR,        // Debug clear strobe, write only
      SEL_TLX_CMD,
      SEL_TLX_RSP,
      SEL_BUF_CNT,
      SEL_TLX_IDLE_LIM,   // Only read-write register
      SEL_FIFO_OVFL,
      SEL_TLX_INTRFC,
      SEL_NONE            // No match or refused access
   } reg_sel_e;

   // Direction of a host access
   typedef enum logic {
      ACC_READ,
      ACC_WRITE
   } access_e;

endpackage

`default_nettype wire

//--- logic/mmio_regfile.sv
/* Stage 2: register storage, writes, read mux and registered response
   Refused requests arrive with SEL_NONE, so req_err only picks done or failed */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module mmio_regfile (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      req_valid,
   input  wire mmio_pkg::access_e   req_kind,
   input  wire mmio_pkg::reg_sel_e  req_sel,
   input  wire                      req_err,
   input  wire [`MMIO_DATA_W-1:0]   req_wdata,
   input  wire [`MMIO_DATA_W-1:0]   debug_tlx_cnt_cmd,
   input  wire [`MMIO_DATA_W-1:0]   debug_tlx_cnt_rsp,
   input  wire [`MMIO_DATA_W-1:0]   debug_buf_cnt,
   input  wire [`MMIO_DATA_W-1:0]   fir_fifo_overflow,
   input  wire [`MMIO_DATA_W-1:0]   fir_tlx_interface,
   output logic [`MMIO_DATA_W-1:0]  mmio_dout,
   output logic                     mmio_done,
   output logic                     mmio_failed,
   output logic                     debug_cnt_clear,     // One-cycle strobe
   output logic [`MMIO_DATA_W-1:0]  debug_tlx_idle_lim,
   output logic                     cmd_start            // To soft reset generator
);

   logic [`MMIO_DATA_W-1:0] frt;              // Free-running time
   logic [`MMIO_DATA_W-1:0] snap_tlx_cmd;
   logic [`MMIO_DATA_W-1:0] snap_tlx_rsp;
   logic [`MMIO_DATA_W-1:0] snap_buf_cnt;
   logic [`MMIO_DATA_W-1:0] snap_fifo_ovfl;
   logic [`MMIO_DATA_W-1:0] snap_tlx_intrfc;
   logic                    st_idle;
   logic                    st_tlx_busy;
   logic                    st_fatal;
   logic [`MMIO_DATA_W-1:0] status_word;
   logic [`MMIO_DATA_W-1:0] cap_word;
   logic [`MMIO_DATA_W-1:0] rd_data;
   logic                    wr_req;
   logic                    rd_req;

   assign wr_req = req_valid && (req_kind == mmio_pkg::ACC_WRITE);
   assign rd_req = req_valid && (req_kind == mmio_pkg::ACC_READ);

   // ====================
   // Status bits and time counter
   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         frt         <= '0;
         st_idle     <= 1'b0;
         st_tlx_busy <= 1'b0;
         st_fatal    <= 1'b0;
      end
      else
      begin
         frt         <= frt + 1'b1;
         st_idle     <= (debug_buf_cnt == '0);                    // Buffers drained
         st_tlx_busy <= (debug_tlx_cnt_cmd != debug_tlx_cnt_rsp); // Commands outstanding
         st_fatal    <= |{fir_fifo_overflow, fir_tlx_interface};
      end

   // Debug and FIR snapshots, one cycle behind the inputs
   always_ff @(posedge clk)
   begin
      snap_tlx_cmd    <= debug_tlx_cnt_cmd;
      snap_tlx_rsp    <= debug_tlx_cnt_rsp;
      snap_buf_cnt    <= debug_buf_cnt;
      snap_fifo_ovfl  <= fir_fifo_overflow;
      snap_tlx_intrfc <= fir_tlx_interface;
   end

   // Bit 2 was AXI busy, reads 0
   assign status_word = {60'd0, st_fatal, 1'b0, st_tlx_busy, st_idle};
   // Bit 8 NVMe is off
   assign cap_word = {24'd0, `DMA_XFER_SIZE, `DMA_ALIGNMENT, `SDRAM_SIZE, 8'd0, `CARD_TYPE};

   // ====================
   // Writes and command strobes
   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         debug_tlx_idle_lim <= '0;
         debug_cnt_clear    <= 1'b0;
         cmd_start          <= 1'b0;
      end
      else
      begin
         if (wr_req && (req_sel == mmio_pkg::SEL_TLX_IDLE_LIM))
            debug_tlx_idle_lim <= req_wdata;
         debug_cnt_clear <= wr_req && (req_sel == mmio_pkg::SEL_DBG_CLR) && req_wdata[0];
         cmd_start       <= wr_req && (req_sel == mmio_pkg::SEL_SCR) && req_wdata[0];
      end

   // Read mux, write-only selects fall to 0
   always_comb
   begin
      case (req_sel)
         mmio_pkg::SEL_IVR:          rd_data = `IMP_VERSION;
         mmio_pkg::SEL_BDR:          rd_data = `BUILD_DATE;
         mmio_pkg::SEL_SSR:          rd_data = status_word;
         mmio_pkg::SEL_CAP:          rd_data = cap_word;
         mmio_pkg::SEL_FRT:          rd_data = frt;
         mmio_pkg::SEL_TLX_CMD:      rd_data = snap_tlx_cmd;
         mmio_pkg::SEL_TLX_RSP:      rd_data = snap_tlx_rsp;
         mmio_pkg::SEL_BUF_CNT:      rd_data = snap_buf_cnt;
         mmio_pkg::SEL_TLX_IDLE_LIM: rd_data = debug_tlx_idle_lim;
         mmio_pkg::SEL_FIFO_OVFL:    rd_data = snap_fifo_ovfl;
         mmio_pkg::SEL_TLX_INTRFC:   rd_data = snap_tlx_intrfc;
         default:                    rd_data = '0;
      endcase
   end

   // ====================
   // Response, two cycles after the host pulse
   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         mmio_dout   <= '0;
         mmio_done   <= 1'b0;
         mmio_failed <= 1'b0;
      end
      else
      begin
         mmio_done   <= req_valid && !req_err;
         mmio_failed <= req_valid && req_err;
         if (rd_req)
            mmio_dout <= rd_data;   // Holds between reads
      end

endmodule

`default_nettype wire

//--- logic/mmio_top.sv
/* MMIO register block top, decode stage, register stage and soft reset generator
   Answers every request exactly two cycles later; the host cannot stall it */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module mmio_top (
   input  wire                      clk,
   input  wire                      rst_n,
   // Host side
   input  wire                      mmio_wr,
   input  wire                      mmio_rd,
   input  wire                      mmio_dw,
   input  wire [`MMIO_ADDR_W-1:0]   mmio_addr,
   input  wire [`MMIO_DATA_W-1:0]   mmio_din,
   output wire [`MMIO_DATA_W-1:0]   mmio_dout,
   output wire                      mmio_done,
   output wire                      mmio_failed,
   // Debug and FIR
   input  wire [`MMIO_DATA_W-1:0]   debug_tlx_cnt_cmd,
   input  wire [`MMIO_DATA_W-1:0]   debug_tlx_cnt_rsp,
   input  wire [`MMIO_DATA_W-1:0]   debug_buf_cnt,
   input  wire [`MMIO_DATA_W-1:0]   fir_fifo_overflow,
   input  wire [`MMIO_DATA_W-1:0]   fir_tlx_interface,
   output wire                      debug_cnt_clear,
   output wire [`MMIO_DATA_W-1:0]   debug_tlx_idle_lim,
   output wire                      soft_reset
);

   // ====================
   // Stage 1 to stage 2
   wire                      req_valid;
   mmio_pkg::access_e        req_kind;
   mmio_pkg::reg_sel_e       req_sel;
   wire                      req_err;
   wire [`MMIO_DATA_W-1:0]   req_wdata;
   wire                      cmd_start;   // SCR bit 0 written

   mmio_decode u_decode (
      .clk(clk), .rst_n(rst_n),
      .mmio_wr(mmio_wr), .mmio_rd(mmio_rd), .mmio_dw(mmio_dw),
      .mmio_addr(mmio_addr), .mmio_din(mmio_din),
      .req_valid(req_valid), .req_kind(req_kind), .req_sel(req_sel),
      .req_err(req_err), .req_wdata(req_wdata)
   );

   mmio_regfile u_regfile (
      .clk(clk), .rst_n(rst_n),
      .req_valid(req_valid), .req_kind(req_kind), .req_sel(req_sel),
      .req_err(req_err), .req_wdata(req_wdata),
      .debug_tlx_cnt_cmd(debug_tlx_cnt_cmd), .debug_tlx_cnt_rsp(debug_tlx_cnt_rsp),
      .debug_buf_cnt(debug_buf_cnt),
      .fir_fifo_overflow(fir_fifo_overflow), .fir_tlx_interface(fir_tlx_interface),
      .mmio_dout(mmio_dout), .mmio_done(mmio_done), .mmio_failed(mmio_failed),
      .debug_cnt_clear(debug_cnt_clear), .debug_tlx_idle_lim(debug_tlx_idle_lim),
      .cmd_start(cmd_start)
   );

   // Soft reset starts the cycle after cmd_start
   soft_reset_gen u_soft_reset (
      .clk(clk), .rst_n(rst_n),
      .cmd_start(cmd_start),
      .soft_reset(soft_reset)
   );

endmodule

`default_nettype wire

//--- logic/soft_reset_gen.sv
/* Stretches cmd_start into a soft-reset pulse of SOFT_RESET_CYCLES cycles
   A strobe during an active pulse is dropped, it does not restart the count */
`default_nettype none
`timescale 1ns/100ps
`include "mmio_cfg.svh"

module soft_reset_gen (
   input  wire   clk,
   input  wire   rst_n,
   input  wire   cmd_start,   // One-cycle strobe
   output logic  soft_reset
);

   localparam int CNT_W = $clog2(`SOFT_RESET_CYCLES);

   logic [CNT_W-1:0] cnt;     // Cycles spent in reset
   logic             active;

   always_ff @(posedge clk or negedge rst_n)
      if (!rst_n)
      begin
         active <= 1'b0;
         cnt    <= '0;
      end
      else if (active)
      begin
         cnt <= cnt + 1'b1;
         if (cnt == CNT_W'(`SOFT_RESET_CYCLES - 1))   // Last cycle of the pulse
         begin
            active <= 1'b0;
            cnt    <= '0;
         end
      end
      else if (cmd_start)
         active <= 1'b1;

   assign soft_reset = active;

endmodule

`default_nettype wire
